// File: dcache_top.f
src/dcache_pkg.sv
src/array_if.sv
src/cache_ctrl.sv
src/tag_store.sv
src/data_store.sv
src/victim_select.sv
src/dcache_top.sv
verification/dcache_tb.sv

// File: Makefile
TOP = dcache_tb

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f dcache_top.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: verification/dcache_tb.sv
module dcache_tb import dcache_pkg::*; ();

    localparam int          NUM_REQS   = 400;
    localparam int          MAX_CYCLES = NUM_REQS * 20;
    // Upper tag bits shared by all four test tags
    localparam logic [17:0] TAG_HI     = 18'h3a5c1;

    logic    clk = 1'b0;
    logic    resetn;
    logic    valid;
    logic    op;
    tag_t    tag;
    index_t  index;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    line_t   ret_data;
    logic    wr_req;
    addr_t   wr_addr;
    line_t   wr_data;
    logic    wr_rdy;

    // Byte memory indexed by {tag low bits, index low bits, offset}
    logic [7:0] mem [512];
    logic [1:0] m_tag   [2][8];
    logic       m_valid [2][8];
    logic       m_dirty [2][8];
    logic       m_last  [8];

    // Request in flight
    logic       pend;
    logic       p_hit;
    logic       p_op;
    logic       p_wb;
    logic       p_rd_seen;
    logic       p_wb_seen;
    logic [1:0] p_tag;
    logic [2:0] p_idx;
    offset_t    p_off;
    strb_t      p_strb;
    word_t      p_data;
    addr_t      p_wb_addr;
    line_t      p_wb_line;
    int         p_cycle;

    int    cycle;
    int    errors;
    int    n_done;
    int    n_issued;
    int    n_hits;
    int    n_misses;
    int    n_wbs;
    int    rd_gap;
    int    wr_gap;
    int    ret_wait;
    logic  ret_pend;
    line_t ret_line;

    dcache_top dcache_top_i (.*);

    always #2 clk = ~clk;

    function automatic line_t line_at(input logic [4:0] lkey);
        line_t l;
        for (int b = 0; b < 16; b++) begin
            l[b*8 +: 8] = mem[{lkey, 4'(b)}];
        end
        return l;
    endfunction

    function automatic logic pick_victim(input logic [2:0] i);
        logic v;
        if (!m_valid[0][i]) begin
            v = 1'b0;
        end else if (!m_valid[1][i]) begin
            v = 1'b1;
        end else if (m_dirty[0][i] != m_dirty[1][i]) begin
            // The clean one goes
            v = m_dirty[0][i];
        end else begin
            v = !m_last[i];
        end
        return v;
    endfunction

    task automatic show_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic flag_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic serve_bus();
        addr_t exp_addr;
        exp_addr = {TAG_HI, p_tag, 5'b0, p_idx, 4'b0000};
        if (rd_req && (!pend || p_hit)) begin
            flag_error("rd_req raised while no miss was outstanding");
        end else if (rd_req && rd_rdy) begin
            if (rd_addr !== exp_addr) begin
                show_mismatch("rd_addr", rd_addr, exp_addr);
            end
            p_rd_seen = 1'b1;
            ret_pend  = 1'b1;
            ret_wait  = int'($urandom % 4);
            ret_line  = line_at({p_tag, p_idx});
        end
        if (wr_req && !(pend && !p_hit && p_wb)) begin
            flag_error("wr_req raised although the victim is not valid and dirty");
        end else if (wr_req && wr_rdy) begin
            if (wr_addr !== p_wb_addr) begin
                show_mismatch("wr_addr", wr_addr, p_wb_addr);
            end
            if (wr_data !== p_wb_line) begin
                show_mismatch("wr_data", wr_data, p_wb_line);
            end
            p_wb_seen = 1'b1;
            n_wbs++;
        end

        // Ready gaps of 0 to 3 cycles per request
        if (rd_req && rd_rdy) begin
            rd_gap = int'($urandom % 4);
        end else if (rd_req && rd_gap > 0) begin
            rd_gap--;
        end
        if (wr_req && wr_rdy) begin
            wr_gap = int'($urandom % 4);
        end else if (wr_req && wr_gap > 0) begin
            wr_gap--;
        end
        rd_rdy <= (rd_gap == 0);
        wr_rdy <= (wr_gap == 0);

        if (ret_valid) begin
            ret_valid <= 1'b0;
        end else if (ret_pend && ret_wait == 0) begin
            ret_valid <= 1'b1;
            ret_data  <= ret_line;
            ret_pend = 1'b0;
        end else if (ret_pend) begin
            ret_wait--;
        end
    endtask

    task automatic finish_request();
        line_t l;
        word_t exp_word;
        if (!pend) begin
            flag_error("data_ok without an outstanding request");
        end else begin
            if (p_hit && cycle != p_cycle + 1) begin
                flag_error("hit did not respond one cycle after acceptance");
            end
            if (!p_hit && !p_rd_seen) begin
                flag_error("miss completed without a refill request");
            end
            if (p_wb && !p_wb_seen) begin
                flag_error("dirty victim was not written back");
            end
            if (p_op) begin
                for (int b = 0; b < 4; b++) begin
                    if (p_strb[b]) begin
                        mem[{p_tag, p_idx, p_off[3:2], 2'(b)}] = p_data[b*8 +: 8];
                    end
                end
            end else begin
                l = line_at({p_tag, p_idx});
                exp_word = l[p_off[3:2]*32 +: 32];
                if (rdata !== exp_word) begin
                    show_mismatch("rdata", rdata, exp_word);
                end
            end
            pend = 1'b0;
            n_done++;
        end
    endtask

    task automatic accept_request();
        logic way;
        p_tag     = tag[1:0];
        p_idx     = index[2:0];
        p_off     = offset;
        p_op      = op;
        p_strb    = wstrb;
        p_data    = wdata;
        pend      = 1'b1;
        p_cycle   = cycle;
        p_rd_seen = 1'b0;
        p_wb_seen = 1'b0;
        p_wb      = 1'b0;
        p_hit     = 1'b1;
        if (m_valid[0][p_idx] && m_tag[0][p_idx] == p_tag) begin
            way = 1'b0;
        end else if (m_valid[1][p_idx] && m_tag[1][p_idx] == p_tag) begin
            way = 1'b1;
        end else begin
            p_hit = 1'b0;
            way   = pick_victim(p_idx);
        end
        if (p_hit) begin
            m_last[p_idx] = way;
            if (p_op) begin
                m_dirty[way][p_idx] = 1'b1;
            end
            n_hits++;
        end else begin
            p_wb      = m_valid[way][p_idx] && m_dirty[way][p_idx];
            p_wb_addr = {TAG_HI, m_tag[way][p_idx], 5'b0, p_idx, 4'b0000};
            p_wb_line = line_at({m_tag[way][p_idx], p_idx});
            m_tag[way][p_idx]   = p_tag;
            m_valid[way][p_idx] = 1'b1;
            m_dirty[way][p_idx] = p_op;
            n_misses++;
        end
    endtask

    task automatic drive_cpu(input logic accept_now);
        if (accept_now || !valid) begin
            if (n_issued < NUM_REQS && ($urandom % 4) != 0) begin
                valid  <= 1'b1;
                op     <= 1'($urandom % 2);
                tag    <= {TAG_HI, 2'($urandom % 4)};
                index  <= 8'($urandom % 8);
                offset <= 4'($urandom % 16);
                wstrb  <= 4'($urandom % 15 + 1);
                wdata  <= $urandom;
                n_issued++;
            end else begin
                valid <= 1'b0;
            end
        end
    endtask

    initial begin
        int   seed_ret;
        int   reset_errors;
        logic accept_now;
        logic exp_ok;
        seed_ret  = $urandom(32'heb49_a2ca);
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        for (int a = 0; a < 512; a++) begin
            mem[a] = 8'((a * 37) ^ (a >> 4));
        end
        for (int i = 0; i < 8; i++) begin
            m_valid[0][i] = 1'b0;
            m_valid[1][i] = 1'b0;
            m_dirty[0][i] = 1'b0;
            m_dirty[1][i] = 1'b0;
            m_last[i]     = 1'b0;
        end
        pend     = 1'b0;
        ret_pend = 1'b0;
        ret_wait = 0;
        rd_gap   = int'($urandom % 4);
        wr_gap   = int'($urandom % 4);
        cycle    = 0;
        errors   = 0;
        n_done   = 0;
        n_issued = 0;
        n_hits   = 0;
        n_misses = 0;
        n_wbs    = 0;

        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            if (data_ok || rd_req || wr_req) begin
                flag_error("data_ok, rd_req or wr_req high before the first request");
            end
            if (addr_ok !== 1'b1) begin
                show_mismatch("addr_ok", addr_ok, 1'b1);
            end
        end
        reset_errors = errors;
        $display("test reset_idle done, %0d errors", reset_errors);

        while (n_done < NUM_REQS && cycle < MAX_CYCLES) begin
            @(posedge clk);
            cycle++;
            accept_now = valid && addr_ok;
            // Ready in IDLE, and in LOOKUP behind a load hit
            exp_ok = !pend || (p_hit && !p_op);
            if (addr_ok !== exp_ok) begin
                show_mismatch("addr_ok", addr_ok, exp_ok);
            end
            serve_bus();
            if (data_ok) begin
                finish_request();
            end
            if (accept_now) begin
                accept_request();
            end
            drive_cpu(accept_now);
        end
        if (n_done < NUM_REQS) begin
            flag_error($sformatf("timeout after %0d cycles with %0d of %0d requests done",
                                 cycle, n_done, NUM_REQS));
        end
        $display("test random_traffic done, %0d requests, %0d errors",
                 n_done, errors - reset_errors);

        $display("requests %0d, hits %0d, misses %0d, write-backs %0d, errors %0d",
                 n_done, n_hits, n_misses, n_wbs, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src/dcache_top.sv
module dcache_top import dcache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    // CPU
    input  logic    valid,
    input  logic    op,
    input  tag_t    tag,
    input  index_t  index,
    input  offset_t offset,
    input  strb_t   wstrb,
    input  word_t   wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    // Refill
    output logic    rd_req,
    output addr_t   rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  line_t   ret_data,
    // Write-back
    output logic    wr_req,
    output addr_t   wr_addr,
    output line_t   wr_data,
    input  logic    wr_rdy
);

    array_if arr_if ();

    way_t                victim_way;
    logic [NUM_WAYS-1:0] way_dirty;
    logic                lookup_miss;

    assign lookup_miss = arr_if.lookup && !arr_if.hit;

    cache_ctrl ctrl_i (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .op         (op),
        .tag        (tag),
        .index      (index),
        .offset     (offset),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy),
        .victim_way (victim_way),
        .arr        (arr_if.ctrl)
    );

    tag_store tag_store_i (
        .clk        (clk),
        .resetn     (resetn),
        .victim_way (victim_way),
        .dirty      (way_dirty),
        .arr        (arr_if.tags)
    );

    data_store data_store_i (
        .clk (clk),
        .arr (arr_if.data)
    );

    victim_select victim_select_i (
        .clk          (clk),
        .resetn       (resetn),
        .way_valid    (arr_if.way_valid),
        .dirty        (way_dirty),
        .hit          (arr_if.hit),
        .hit_way      (arr_if.hit_way),
        .lookup_index (arr_if.lk_index),
        .miss         (lookup_miss),
        .victim_way   (victim_way)
    );

endmodule

// File: src/victim_select.sv
module victim_select import dcache_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    input  logic [NUM_WAYS-1:0] way_valid,
    input  logic [NUM_WAYS-1:0] dirty,
    input  logic                hit,
    input  way_t                hit_way,
    input  index_t              lookup_index,
    input  logic                miss,
    output way_t                victim_way
);

    logic [NUM_SETS-1:0] last_hit;
    way_t                choice;

    // Invalid first, then clean, then the way not hit last
    always_comb begin
        if (!way_valid[0]) begin
            choice = way_t'(0);
        end else if (!way_valid[1]) begin
            choice = way_t'(1);
        end else if (!dirty[0] && dirty[1]) begin
            choice = way_t'(0);
        end else if (dirty[0] && !dirty[1]) begin
            choice = way_t'(1);
        end else begin
            choice = way_t'(!last_hit[lookup_index]);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            last_hit   <= '0;
            victim_way <= '0;
        end else begin
            if (hit) begin
                last_hit[lookup_index] <= hit_way;
            end
            // Held until the refill is done
            if (miss) begin
                victim_way <= choice;
            end
        end
    end

endmodule

// File: src/data_store.sv
module data_store import dcache_pkg::*; (
    input  logic  clk,
    array_if.data arr
);

    line_t way_line [NUM_WAYS];
    line_t merged;

    // Store-miss bytes laid over the returned line
    always_comb begin
        merged = arr.refill_line;
        if (arr.lk_store) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (arr.lk_wstrb[b]) begin
                    merged[arr.lk_offset[3:2]*32 + b*8 +: 8] = arr.lk_wdata[b*8 +: 8];
                end
            end
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        line_t rd_line;

        for (genvar k = 0; k < WORDS_PER_LINE; k++) begin : g_bank
            word_t mem [NUM_SETS];
            word_t rd_q;
            logic  hit_here;
            logic  fill_here;
            word_t wr_word;
            strb_t wr_strb;

            assign hit_here  = arr.hit_write && (arr.hit_way == way_t'(w)) &&
                               (arr.lk_offset[3:2] == k);
            assign fill_here = arr.refill_en && (arr.refill_way == way_t'(w));

            // Refill writes the whole word, a store hit only its strobes
            assign wr_word = fill_here ? merged[k*32 +: 32] : arr.lk_wdata;
            assign wr_strb = fill_here ? '1 : (hit_here ? arr.lk_wstrb : '0);

            always_ff @(posedge clk) begin
                for (int i = 0; i < $bits(strb_t); i++) begin
                    if (wr_strb[i]) begin
                        mem[arr.lk_index][i*8 +: 8] <= wr_word[i*8 +: 8];
                    end
                end
                if (arr.rd_en) begin
                    rd_q <= mem[arr.rd_index];
                end
            end

            assign rd_line[k*32 +: 32] = rd_q;
        end

        assign way_line[w] = rd_line;
    end

    assign arr.load_word   = way_line[arr.hit_way][arr.lk_offset[3:2]*32 +: 32];
    assign arr.victim_line = way_line[arr.refill_way];

endmodule

// File: src/tag_store.sv
module tag_store import dcache_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    input  way_t                victim_way,
    output logic [NUM_WAYS-1:0] dirty,
    array_if.tags               arr
);

    tag_t                way_tag [NUM_WAYS];
    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] valid_now;
    logic [NUM_WAYS-1:0] dirty_now;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        tag_t                mem [NUM_SETS];
        tag_t                tag_q;
        logic [NUM_SETS-1:0] valid_q;
        logic [NUM_SETS-1:0] dirty_q;
        logic                refill_here;
        logic                store_here;

        assign refill_here = arr.refill_en && (arr.refill_way == way_t'(w));
        assign store_here  = arr.hit_write && (arr.hit_way == way_t'(w));

        // Synchronous read at acceptance
        always_ff @(posedge clk) begin
            if (refill_here) begin
                mem[arr.lk_index] <= arr.lk_tag;
            end
            if (arr.rd_en) begin
                tag_q <= mem[arr.rd_index];
            end
        end

        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_q <= '0;
                dirty_q <= '0;
            end else if (refill_here) begin
                valid_q[arr.lk_index] <= 1'b1;
                // A store miss leaves the new line dirty
                dirty_q[arr.lk_index] <= arr.lk_store;
            end else if (store_here) begin
                dirty_q[arr.lk_index] <= 1'b1;
            end
        end

        assign valid_now[w] = valid_q[arr.lk_index];
        assign dirty_now[w] = dirty_q[arr.lk_index];
        assign way_tag[w]   = tag_q;
        assign way_hit[w]   = arr.lookup && valid_q[arr.lk_index] && (tag_q == arr.lk_tag);
    end

    assign arr.hit       = |way_hit;
    // Two ways, so way 1 hitting names the way
    assign arr.hit_way   = way_t'(way_hit[1]);
    assign arr.way_valid = valid_now;
    assign dirty         = dirty_now;

    assign arr.victim_tag   = way_tag[victim_way];
    assign arr.victim_dirty = valid_now[victim_way] && dirty_now[victim_way];

    a_single_hit: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(way_hit));

endmodule

// File: src/cache_ctrl.sv
module cache_ctrl import dcache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    // CPU
    input  logic    valid,
    input  logic    op,
    input  tag_t    tag,
    input  index_t  index,
    input  offset_t offset,
    input  strb_t   wstrb,
    input  word_t   wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    // Refill
    output logic    rd_req,
    output addr_t   rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  line_t   ret_data,
    // Write-back
    output logic    wr_req,
    output addr_t   wr_addr,
    output line_t   wr_data,
    input  logic    wr_rdy,
    input  way_t    victim_way,
    array_if.ctrl   arr
);

    cache_state_e state;
    cache_state_e next_state;
    logic         accept;
    logic         lookup_hit;

    assign lookup_hit = (state == LOOKUP) && arr.hit;

    // Back-to-back acceptance only behind a load hit
    assign addr_ok = (state == IDLE) || (lookup_hit && !arr.lk_store);
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (accept) next_state = LOOKUP;
            LOOKUP: begin
                if (!arr.hit) begin
                    next_state = MISS;
                end else if (!accept) begin
                    next_state = IDLE;
                end
            end
            MISS:    if (!arr.victim_dirty || wr_rdy) next_state = REPLACE;
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (ret_valid) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // Request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            arr.lk_store  <= op;
            arr.lk_tag    <= tag;
            arr.lk_index  <= index;
            arr.lk_offset <= offset;
            arr.lk_wstrb  <= wstrb;
            arr.lk_wdata  <= wdata;
        end
    end

    // Array requests
    assign arr.rd_en       = accept;
    assign arr.rd_index    = index;
    assign arr.lookup      = (state == LOOKUP);
    assign arr.hit_write   = lookup_hit && arr.lk_store;
    assign arr.refill_en   = (state == REFILL) && ret_valid;
    assign arr.refill_way  = victim_way;
    assign arr.refill_line = ret_data;

    assign data_ok = lookup_hit || arr.refill_en;
    assign rdata   = (state == REFILL) ? ret_data[arr.lk_offset[3:2]*32 +: 32]
                                       : arr.load_word;

    // Line-aligned bus addresses
    assign rd_req  = (state == REPLACE);
    assign rd_addr = {arr.lk_tag, arr.lk_index, 4'b0000};
    assign wr_req  = (state == MISS) && arr.victim_dirty;
    assign wr_addr = {arr.victim_tag, arr.lk_index, 4'b0000};
    assign wr_data = arr.victim_line;

    a_bus_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req));

    a_no_resp_in_miss: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> !(state inside {MISS, REPLACE}));

endmodule

// File: src/array_if.sv
interface array_if import dcache_pkg::*; ();

    // Controller side
    logic    rd_en;
    index_t  rd_index;
    index_t  lk_index;
    tag_t    lk_tag;
    offset_t lk_offset;
    strb_t   lk_wstrb;
    word_t   lk_wdata;
    logic    lk_store;
    logic    lookup;
    logic    hit_write;
    logic    refill_en;
    way_t    refill_way;
    line_t   refill_line;

    // Storage side
    logic                hit;
    way_t                hit_way;
    tag_t                victim_tag;
    logic                victim_dirty;
    logic [NUM_WAYS-1:0] way_valid;
    word_t               load_word;
    line_t               victim_line;

    modport ctrl (
        output rd_en, rd_index, lk_index, lk_tag, lk_offset, lk_wstrb, lk_wdata, lk_store,
        output lookup, hit_write, refill_en, refill_way, refill_line,
        input  hit, hit_way, victim_tag, victim_dirty, load_word, victim_line
    );

    modport tags (
        input  rd_en, rd_index, lk_index, lk_tag, lk_store, lookup, hit_write,
        input  refill_en, refill_way,
        output hit, hit_way, victim_tag, victim_dirty, way_valid
    );

    modport data (
        input  rd_en, rd_index, lk_index, lk_offset, lk_wstrb, lk_wdata, lk_store,
        input  hit_write, hit_way, refill_en, refill_way, refill_line,
        output load_word, victim_line
    );

endinterface

// File: src/dcache_pkg.sv
package dcache_pkg;

    // Geometry
    localparam int NUM_SETS       = 256;
    localparam int NUM_WAYS       = 2;
    localparam int WORDS_PER_LINE = 4;

    // Address fields, tag above index above offset
    typedef logic [19:0] tag_t;
    typedef logic [7:0]  index_t;
    // Bits [3:2] pick the word, [1:0] the byte
    typedef logic [3:0]  offset_t;
    typedef logic [31:0] addr_t;

    // Data
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    // Word 0 sits in the low bits
    typedef logic [127:0] line_t;

    typedef logic [0:0] way_t;

    // Main controller FSM
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } cache_state_e;

endpackage
